/* logic/snes_bridge_pkg.sv */
/*
  Shared definitions for the bridge control logic.
  Holds the address windows, the settings register offsets, the data table
  constants, and the packed structs for settings, bridge bus, save port and RTC.
*/
package snes_bridge_pkg;

  // upper address nibble of each bridge window
  localparam logic [3:0] window_settings = 4'h0;
  localparam logic [3:0] window_save     = 4'h2;
  localparam logic [3:0] window_cmd      = 4'hF;

  ////////////////////////////////////////////////////////////
  // settings register byte offsets
  localparam logic [31:0] reg_ioctl_download = 32'h0000_0000;
  localparam logic [31:0] reg_rom_size       = 32'h0000_0004;
  localparam logic [31:0] reg_rom_type       = 32'h0000_0008;
  localparam logic [31:0] reg_ram_size       = 32'h0000_000C;
  localparam logic [31:0] reg_pal            = 32'h0000_0010;
  localparam logic [31:0] reg_reset          = 32'h0000_0050;
  localparam logic [31:0] reg_cpu_turbo      = 32'h0000_0080;
  localparam logic [31:0] reg_gsu_turbo      = 32'h0000_0084;
  localparam logic [31:0] reg_multitap       = 32'h0000_0100;
  localparam logic [31:0] reg_lightgun       = 32'h0000_0104;
  localparam logic [31:0] reg_aim_speed      = 32'h0000_0108;
  localparam logic [31:0] reg_aspect         = 32'h0000_0200;
  localparam logic [31:0] reg_blend          = 32'h0000_0204;

  // size word of data slot 1 in the data table
  localparam logic [9:0]  datatable_size_index = 10'd3;
  localparam logic [31:0] save_size_base       = 32'd1024;

  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic       ioctl_download;
    logic [7:0] rom_type;
    logic [3:0] rom_size;
    logic [3:0] ram_size;
    logic       pal;
    logic       cpu_turbo;
    logic       gsu_turbo;
    logic       multitap;
    logic       lightgun_enabled;
    logic       lightgun_type;
    logic [7:0] aim_speed;
    logic       use_4_3;
    logic       blend;
  } core_settings_t;

  typedef struct packed {
    logic [31:0] addr;
    logic        rd;
    logic        wr;
    logic [31:0] wr_data;
  } bridge_bus_t;

  // core side save port, 16-bit word address
  typedef struct packed {
    logic        wr;
    logic [10:0] addr;
    logic [15:0] wdata;
  } core_save_req_t;

  typedef struct packed {
    logic       toggle;
    logic [7:0] pad;
    logic [7:0] weekday;
    logic [7:0] year;
    logic [7:0] month;
    logic [7:0] day;
    logic [7:0] hour;
    logic [7:0] minute;
    logic [7:0] second;
  } rtc_word_t;

endpackage

/* logic/bridge_settings_regs.sv */
/*
  Settings register file on the bridge bus.
  Decodes writes into the settings struct, runs the core reset pulse counter
  and returns registered readback of every register.
*/
`timescale 1ns/10ps

module bridge_settings_regs #(
  parameter int unsigned reset_hold_cycles = 1048576
) (
  input  logic                            clk_74a,
  input  logic                            pll_core_locked,
  input  snes_bridge_pkg::bridge_bus_t    bridge,
  output snes_bridge_pkg::core_settings_t settings,
  output logic                            reset_button,
  output logic [31:0]                     rd_data
);

  localparam int cnt_w = $clog2(reset_hold_cycles + 1);

  logic             in_window;
  logic [31:0]      offset;
  logic             reset_wr;
  logic [cnt_w-1:0] reset_cnt;
  logic [31:0]      rd_word;

  assign in_window = bridge.addr[31:28] == snes_bridge_pkg::window_settings;
  assign offset    = {4'h0, bridge.addr[27:0]};
  assign reset_wr  = bridge.wr && in_window && (offset == snes_bridge_pkg::reg_reset);

  ////////////////////////////////////////////////////////////
  // write decode
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings <= '0;
    end else if (bridge.wr && in_window) begin
      case (offset)
        snes_bridge_pkg::reg_ioctl_download: settings.ioctl_download <= bridge.wr_data[0];
        snes_bridge_pkg::reg_rom_size:       settings.rom_size <= bridge.wr_data[3:0];
        snes_bridge_pkg::reg_rom_type:       settings.rom_type <= bridge.wr_data[7:0];
        snes_bridge_pkg::reg_ram_size:       settings.ram_size <= bridge.wr_data[3:0];
        snes_bridge_pkg::reg_pal:            settings.pal <= bridge.wr_data[0];
        snes_bridge_pkg::reg_cpu_turbo:      settings.cpu_turbo <= bridge.wr_data[0];
        snes_bridge_pkg::reg_gsu_turbo:      settings.gsu_turbo <= bridge.wr_data[0];
        snes_bridge_pkg::reg_multitap:       settings.multitap <= bridge.wr_data[0];
        snes_bridge_pkg::reg_lightgun: begin
          settings.lightgun_enabled <= bridge.wr_data[0];
          settings.lightgun_type    <= bridge.wr_data[1];
        end
        snes_bridge_pkg::reg_aim_speed:      settings.aim_speed <= bridge.wr_data[7:0];
        snes_bridge_pkg::reg_aspect:         settings.use_4_3 <= bridge.wr_data[0];
        snes_bridge_pkg::reg_blend:          settings.blend <= bridge.wr_data[0];
        default: ;
      endcase
    end
  end

  // core reset pulse, high while the counter runs
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      reset_cnt <= '0;
    end else if (reset_wr) begin
      reset_cnt <= cnt_w'(reset_hold_cycles);
    end else if (reset_cnt != '0) begin
      reset_cnt <= reset_cnt - 1'b1;
    end
  end

  assign reset_button = reset_cnt != '0;

  ////////////////////////////////////////////////////////////
  // readback, unused bits read as zero
  always_comb begin
    case (offset)
      snes_bridge_pkg::reg_ioctl_download: rd_word = {31'h0, settings.ioctl_download};
      snes_bridge_pkg::reg_rom_size:       rd_word = {28'h0, settings.rom_size};
      snes_bridge_pkg::reg_rom_type:       rd_word = {24'h0, settings.rom_type};
      snes_bridge_pkg::reg_ram_size:       rd_word = {28'h0, settings.ram_size};
      snes_bridge_pkg::reg_pal:            rd_word = {31'h0, settings.pal};
      snes_bridge_pkg::reg_reset:          rd_word = {31'h0, reset_button};
      snes_bridge_pkg::reg_cpu_turbo:      rd_word = {31'h0, settings.cpu_turbo};
      snes_bridge_pkg::reg_gsu_turbo:      rd_word = {31'h0, settings.gsu_turbo};
      snes_bridge_pkg::reg_multitap:       rd_word = {31'h0, settings.multitap};
      snes_bridge_pkg::reg_lightgun:
        rd_word = {30'h0, settings.lightgun_type, settings.lightgun_enabled};
      snes_bridge_pkg::reg_aim_speed:      rd_word = {24'h0, settings.aim_speed};
      snes_bridge_pkg::reg_aspect:         rd_word = {31'h0, settings.use_4_3};
      snes_bridge_pkg::reg_blend:          rd_word = {31'h0, settings.blend};
      default:                             rd_word = 32'h0;
    endcase
  end

  always_ff @(posedge clk_74a) begin
    if (bridge.rd && in_window) begin
      rd_data <= rd_word;
    end
  end

endmodule

/* logic/save_slot_buffer.sv */
/*
  Save slot memory shared by the bridge and the core save port.
  Two banks of 16-bit words; a bridge word spans one entry in each bank.
  Bridge writes always win, core writes are blocked during a save session.
*/
`timescale 1ns/10ps

module save_slot_buffer #(
  parameter int unsigned save_addr_w = 10
) (
  input  logic                           clk_74a,
  input  logic                           pll_core_locked,
  input  snes_bridge_pkg::bridge_bus_t    bridge,
  input  logic                           save_download,
  input  snes_bridge_pkg::core_save_req_t core_save_req,
  output logic [15:0]                    core_save_rdata,
  output logic [31:0]                    rd_data
);

  localparam int depth = 1 << save_addr_w;

  // bank 0 holds even words, bank 1 odd words
  logic [15:0] bank_mem [2][depth];

  logic                   in_window;
  logic                   bridge_save_wr;
  logic                   bridge_save_rd;
  logic [save_addr_w-1:0] bridge_idx;
  logic [save_addr_w-1:0] core_idx;
  logic                   core_bank;
  logic                   core_wr_ok;
  logic                   core_blocked;

  logic [1:0]             bank_we;
  logic [save_addr_w-1:0] bank_addr [2];
  logic [15:0]            bank_wdata [2];

  assign in_window      = bridge.addr[31:28] == snes_bridge_pkg::window_save;
  assign bridge_save_wr = bridge.wr && in_window;
  assign bridge_save_rd = bridge.rd && in_window;

  // byte address to 32-bit word index
  assign bridge_idx = bridge.addr[save_addr_w+1:2];
  assign core_idx   = core_save_req.addr[save_addr_w:1];
  assign core_bank  = core_save_req.addr[0];

  ////////////////////////////////////////////////////////////
  // arbiter
  // the bridge owns both banks during its write cycle
  assign core_blocked = save_download || bridge_save_wr;
  assign core_wr_ok   = core_save_req.wr && !core_blocked;

  always_comb begin
    for (int b = 0; b < 2; b++) begin
      bank_we[b]   = bridge_save_wr || (core_wr_ok && (core_bank == b[0]));
      bank_addr[b] = bridge_save_wr ? bridge_idx : core_idx;
      if (bridge_save_wr) begin
        // big endian bridge, upper half goes to the even word
        bank_wdata[b] = (b == 0) ? bridge.wr_data[31:16] : bridge.wr_data[15:0];
      end else begin
        bank_wdata[b] = core_save_req.wdata;
      end
    end
  end

  always_ff @(posedge clk_74a) begin
    for (int b = 0; b < 2; b++) begin
      if (bank_we[b]) begin
        bank_mem[b][bank_addr[b]] <= bank_wdata[b];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read ports
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      core_save_rdata <= '0;
    end else begin
      core_save_rdata <= bank_mem[core_bank][core_idx];
    end
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      rd_data <= '0;
    end else if (bridge_save_rd) begin
      rd_data <= {bank_mem[0][bridge_idx], bank_mem[1][bridge_idx]};
    end
  end

endmodule

/* logic/save_session_tracker.sv */
/*
  Save session flag and data table size writer.
*/
`timescale 1ns/10ps

module save_session_tracker (
  input  logic        clk_74a,
  input  logic        pll_core_locked,
  input  logic        dataslot_requestread,
  input  logic        dataslot_requestwrite,
  input  logic        dataslot_allcomplete,
  input  logic [3:0]  ram_size,
  output logic        save_download,
  output logic [9:0]  datatable_addr,
  output logic        datatable_wren,
  output logic [31:0] datatable_data
);

  logic allcomplete_q;
  logic allcomplete_rise;

  assign allcomplete_rise = dataslot_allcomplete && !allcomplete_q;

  // session opens on any slot request, closes on complete edge
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      allcomplete_q <= 1'b0;
      save_download <= 1'b0;
    end else begin
      allcomplete_q <= dataslot_allcomplete;
      if (dataslot_requestread || dataslot_requestwrite) begin
        save_download <= 1'b1;
      end else if (allcomplete_rise) begin
        save_download <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // size of data slot 1, rewritten every cycle
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      datatable_addr <= '0;
      datatable_wren <= 1'b0;
      datatable_data <= '0;
    end else begin
      datatable_addr <= snes_bridge_pkg::datatable_size_index;
      datatable_wren <= 1'b1;
      datatable_data <= (ram_size != 4'h0) ? snes_bridge_pkg::save_size_base << ram_size
                                           : 32'h0;
    end
  end

endmodule

/* logic/rtc_packer.sv */
/*
  RTC word for the core, with a toggle that flips on every new time.
*/
`timescale 1ns/10ps

module rtc_packer (
  input  logic                       clk_74a,
  input  logic                       pll_core_locked,
  input  logic [31:0]                rtc_date,
  input  logic [31:0]                rtc_time,
  output snes_bridge_pkg::rtc_word_t rtc
);

  logic [31:0] prev_time;
  logic        new_rtc;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      prev_time <= '0;
      new_rtc   <= 1'b0;
    end else if (rtc_time != prev_time) begin
      prev_time <= rtc_time;
      new_rtc   <= !new_rtc;
    end
  end

  always_comb begin
    rtc.toggle  = new_rtc;
    rtc.pad     = 8'h00;
    // weekday is not tracked by the host
    rtc.weekday = 8'h01;
    rtc.year    = rtc_date[23:16];
    rtc.month   = rtc_date[15:8];
    rtc.day     = rtc_date[7:0];
    rtc.hour    = rtc_time[23:16];
    rtc.minute  = rtc_time[15:8];
    rtc.second  = rtc_time[7:0];
  end

endmodule

/* logic/bridge_read_mux.sv */
/*
  Bridge read data select by address window, one register stage.
*/
`timescale 1ns/10ps

module bridge_read_mux (
  input  logic                         clk_74a,
  input  logic                         pll_core_locked,
  input  snes_bridge_pkg::bridge_bus_t bridge,
  input  logic [31:0]                  settings_rd_data,
  input  logic [31:0]                  save_rd_data,
  output logic [31:0]                  bridge_rd_data
);

  logic       rd_q;
  logic [3:0] win_q;

  // peers register their word in the cycle after the read
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      rd_q           <= 1'b0;
      win_q          <= '0;
      bridge_rd_data <= '0;
    end else begin
      rd_q <= bridge.rd;
      if (bridge.rd) begin
        win_q <= bridge.addr[31:28];
      end
      if (rd_q) begin
        case (win_q)
          snes_bridge_pkg::window_save:     bridge_rd_data <= save_rd_data;
          snes_bridge_pkg::window_settings: bridge_rd_data <= settings_rd_data;
          // no host command handler behind the command window
          default:                          bridge_rd_data <= 32'h0;
        endcase
      end
    end
  end

endmodule

/* logic/snes_bridge_top.sv */
/*
  Bridge side control logic top level.
  Settings registers, save slot buffer, save session tracker, RTC packer
  and the bridge read mux.
*/
`timescale 1ns/10ps

module snes_bridge_top #(
  parameter int unsigned save_addr_w       = 10,
  parameter int unsigned reset_hold_cycles = 1048576
) (
  input  logic                            clk_74a,
  input  logic                            pll_core_locked,
  input  snes_bridge_pkg::bridge_bus_t    bridge,
  input  logic                            dataslot_requestread,
  input  logic                            dataslot_requestwrite,
  input  logic                            dataslot_allcomplete,
  input  logic [31:0]                     rtc_date,
  input  logic [31:0]                     rtc_time,
  input  snes_bridge_pkg::core_save_req_t core_save_req,
  output logic [31:0]                     bridge_rd_data,
  output snes_bridge_pkg::core_settings_t settings,
  output logic                            reset_button,
  output logic                            save_download,
  output logic [9:0]                      datatable_addr,
  output logic                            datatable_wren,
  output logic [31:0]                     datatable_data,
  output snes_bridge_pkg::rtc_word_t      rtc,
  output logic [15:0]                     core_save_rdata
);

  logic [31:0] settings_rd_data;
  logic [31:0] save_rd_data;

  ////////////////////////////////////////////////////////////
  // bridge peers, writes are broadcast to both
  bridge_settings_regs #(
    .reset_hold_cycles(reset_hold_cycles)
  ) i_settings (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge         (bridge),
    .settings       (settings),
    .reset_button   (reset_button),
    .rd_data        (settings_rd_data)
  );

  save_slot_buffer #(
    .save_addr_w(save_addr_w)
  ) i_save_buf (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge         (bridge),
    .save_download  (save_download),
    .core_save_req  (core_save_req),
    .core_save_rdata(core_save_rdata),
    .rd_data        (save_rd_data)
  );

  bridge_read_mux i_read_mux (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge          (bridge),
    .settings_rd_data(settings_rd_data),
    .save_rd_data    (save_rd_data),
    .bridge_rd_data  (bridge_rd_data)
  );

  ////////////////////////////////////////////////////////////
  save_session_tracker i_session (
    .clk_74a              (clk_74a),
    .pll_core_locked      (pll_core_locked),
    .dataslot_requestread (dataslot_requestread),
    .dataslot_requestwrite(dataslot_requestwrite),
    .dataslot_allcomplete (dataslot_allcomplete),
    .ram_size             (settings.ram_size),
    .save_download        (save_download),
    .datatable_addr       (datatable_addr),
    .datatable_wren       (datatable_wren),
    .datatable_data       (datatable_data)
  );

  rtc_packer i_rtc (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .rtc_date       (rtc_date),
    .rtc_time       (rtc_time),
    .rtc            (rtc)
  );

endmodule

/* dv/snes_bridge_checker.sv */
/*
  Concurrent assertions on the top level, bound to snes_bridge_top.
  Data table address, save session start and reset pulse origin.
*/
`timescale 1ns/10ps

module snes_bridge_checker #(
  parameter int unsigned reset_hold_cycles = 1048576
) (
  input logic                         clk_74a,
  input logic                         pll_core_locked,
  input snes_bridge_pkg::bridge_bus_t bridge,
  input logic                         dataslot_requestread,
  input logic                         dataslot_requestwrite,
  input logic                         save_download,
  input logic                         reset_button,
  input logic                         datatable_wren,
  input logic [9:0]                   datatable_addr
);

  logic        reset_wr;
  logic [31:0] since_reset_wr;

  assign reset_wr = bridge.wr && (bridge.addr == snes_bridge_pkg::reg_reset);

  // cycles since the last reset write, saturating
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      since_reset_wr <= 32'hFFFF_FFFF;
    end else if (reset_wr) begin
      since_reset_wr <= 32'h0;
    end else if (since_reset_wr != 32'hFFFF_FFFF) begin
      since_reset_wr <= since_reset_wr + 32'h1;
    end
  end

  ////////////////////////////////////////////////////////////
  a_datatable_addr: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    datatable_wren |-> datatable_addr == snes_bridge_pkg::datatable_size_index)
    else $error("datatable write outside the size index");

  a_session_start: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    $rose(save_download) |-> $past(dataslot_requestread || dataslot_requestwrite))
    else $error("save_download rose without a slot request");

  a_reset_origin: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    reset_button |-> since_reset_wr < reset_hold_cycles + 1)
    else $error("reset_button high without a recent reset write");

endmodule

bind snes_bridge_top snes_bridge_checker #(
  .reset_hold_cycles(reset_hold_cycles)
) i_checker (
  .clk_74a              (clk_74a),
  .pll_core_locked      (pll_core_locked),
  .bridge               (bridge),
  .dataslot_requestread (dataslot_requestread),
  .dataslot_requestwrite(dataslot_requestwrite),
  .save_download        (save_download),
  .reset_button         (reset_button),
  .datatable_wren       (datatable_wren),
  .datatable_addr       (datatable_addr)
);

/* dv/snes_bridge_tb.sv */
/*
  Directed testbench for the bridge control logic top level.
  Clock and reset, bridge and core port driver tasks, and the tests for
  settings, reset pulse, save window, save session, data table and RTC.
*/
`timescale 1ns/10ps

module snes_bridge_tb;

  localparam int unsigned hold_cycles = 16;

  logic                            clk_74a;
  logic                            pll_core_locked;
  snes_bridge_pkg::bridge_bus_t    bridge;
  logic                            dataslot_requestread;
  logic                            dataslot_requestwrite;
  logic                            dataslot_allcomplete;
  logic [31:0]                     rtc_date;
  logic [31:0]                     rtc_time;
  snes_bridge_pkg::core_save_req_t core_save_req;
  logic [31:0]                     bridge_rd_data;
  snes_bridge_pkg::core_settings_t settings;
  logic                            reset_button;
  logic                            save_download;
  logic [9:0]                      datatable_addr;
  logic                            datatable_wren;
  logic [31:0]                     datatable_data;
  snes_bridge_pkg::rtc_word_t      rtc;
  logic [15:0]                     core_save_rdata;

  // words written through the save window, reused by the session test
  logic [9:0]  save_idx  [8];
  logic [31:0] save_word [8];

  snes_bridge_top #(
    .reset_hold_cycles(hold_cycles)
  ) i_dut (
    .clk_74a              (clk_74a),
    .pll_core_locked      (pll_core_locked),
    .bridge               (bridge),
    .dataslot_requestread (dataslot_requestread),
    .dataslot_requestwrite(dataslot_requestwrite),
    .dataslot_allcomplete (dataslot_allcomplete),
    .rtc_date             (rtc_date),
    .rtc_time             (rtc_time),
    .core_save_req        (core_save_req),
    .bridge_rd_data       (bridge_rd_data),
    .settings             (settings),
    .reset_button         (reset_button),
    .save_download        (save_download),
    .datatable_addr       (datatable_addr),
    .datatable_wren       (datatable_wren),
    .datatable_data       (datatable_data),
    .rtc                  (rtc),
    .core_save_rdata      (core_save_rdata)
  );

  always #4 clk_74a = ~clk_74a;

  ////////////////////////////////////////////////////////////
  // reporting
  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got === want) else
      stop_run($sformatf("** Error at %0t ns: %s = 0x%0h, expected 0x%0h",
                         $time, name, got, want));
  endtask

  ////////////////////////////////////////////////////////////
  // bus drivers
  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_74a);
    bridge <= '{addr: addr, rd: 1'b0, wr: 1'b1, wr_data: data};
    @(posedge clk_74a);
    bridge.wr <= 1'b0;
  endtask

  // data is valid two cycles after the read cycle
  task automatic bridge_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk_74a);
    bridge <= '{addr: addr, rd: 1'b1, wr: 1'b0, wr_data: 32'h0};
    @(posedge clk_74a);
    bridge.rd <= 1'b0;
    @(posedge clk_74a);
    @(negedge clk_74a);
    data = bridge_rd_data;
  endtask

  task automatic core_write(input logic [10:0] addr, input logic [15:0] data);
    @(posedge clk_74a);
    core_save_req <= '{wr: 1'b1, addr: addr, wdata: data};
    @(posedge clk_74a);
    core_save_req.wr <= 1'b0;
  endtask

  task automatic core_read(input logic [10:0] addr, output logic [15:0] data);
    @(posedge clk_74a);
    core_save_req <= '{wr: 1'b0, addr: addr, wdata: 16'h0};
    @(posedge clk_74a);
    @(negedge clk_74a);
    data = core_save_rdata;
  endtask

  function automatic logic [31:0] save_addr(input logic [9:0] idx);
    return {snes_bridge_pkg::window_save, 16'h0, idx, 2'b00};
  endfunction

  // settings output field that belongs to a register offset
  function automatic logic [31:0] settings_field(input logic [31:0] offs);
    case (offs)
      snes_bridge_pkg::reg_ioctl_download: return {31'h0, settings.ioctl_download};
      snes_bridge_pkg::reg_rom_size:       return {28'h0, settings.rom_size};
      snes_bridge_pkg::reg_rom_type:       return {24'h0, settings.rom_type};
      snes_bridge_pkg::reg_ram_size:       return {28'h0, settings.ram_size};
      snes_bridge_pkg::reg_pal:            return {31'h0, settings.pal};
      snes_bridge_pkg::reg_cpu_turbo:      return {31'h0, settings.cpu_turbo};
      snes_bridge_pkg::reg_gsu_turbo:      return {31'h0, settings.gsu_turbo};
      snes_bridge_pkg::reg_multitap:       return {31'h0, settings.multitap};
      snes_bridge_pkg::reg_lightgun:
        return {30'h0, settings.lightgun_type, settings.lightgun_enabled};
      snes_bridge_pkg::reg_aim_speed:      return {24'h0, settings.aim_speed};
      snes_bridge_pkg::reg_aspect:         return {31'h0, settings.use_4_3};
      default:                             return {31'h0, settings.blend};
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // tests
  task automatic settings_roundtrip();
    logic [31:0] offs  [12];
    logic [31:0] masks [12];
    logic [31:0] vals  [12];
    logic [31:0] got;
    offs = '{snes_bridge_pkg::reg_ioctl_download, snes_bridge_pkg::reg_rom_size,
             snes_bridge_pkg::reg_rom_type, snes_bridge_pkg::reg_ram_size,
             snes_bridge_pkg::reg_pal, snes_bridge_pkg::reg_cpu_turbo,
             snes_bridge_pkg::reg_gsu_turbo, snes_bridge_pkg::reg_multitap,
             snes_bridge_pkg::reg_lightgun, snes_bridge_pkg::reg_aim_speed,
             snes_bridge_pkg::reg_aspect, snes_bridge_pkg::reg_blend};
    masks = '{32'h1, 32'hF, 32'hFF, 32'hF, 32'h1, 32'h1,
              32'h1, 32'h1, 32'h3, 32'hFF, 32'h1, 32'h1};
    for (int i = 0; i < 12; i++) begin
      vals[i] = $urandom;
      bridge_write(offs[i], vals[i]);
      @(negedge clk_74a);
      check_value($sformatf("settings field @0x%0h", offs[i]),
                  settings_field(offs[i]), vals[i] & masks[i]);
    end
    for (int i = 0; i < 12; i++) begin
      bridge_read(offs[i], got);
      check_value("bridge_rd_data", got, vals[i] & masks[i]);
    end
  endtask

  task automatic reset_pulse_length();
    int cnt;
    int n;
    cnt = 0;
    n   = 0;
    bridge_write(snes_bridge_pkg::reg_reset, 32'h1);
    @(negedge clk_74a);
    assert (reset_button) else stop_run("reset_button did not rise after the reset write");
    while (reset_button && n < 64) begin
      cnt++;
      n++;
      @(negedge clk_74a);
    end
    assert (!reset_button) else stop_run("reset_button stayed high past the timeout");
    check_value("reset_button high cycles", 32'(cnt), 32'(hold_cycles));
  endtask

  task automatic save_window_access();
    logic [31:0] got;
    logic [15:0] half;
    for (int i = 0; i < 8; i++) begin
      // low bits from the loop index keep the words distinct
      save_idx[i]  = {7'($urandom), 3'(i)};
      save_word[i] = $urandom;
      bridge_write(save_addr(save_idx[i]), save_word[i]);
    end
    for (int i = 0; i < 8; i++) begin
      bridge_read(save_addr(save_idx[i]), got);
      check_value("bridge_rd_data", got, save_word[i]);
      core_read({save_idx[i], 1'b0}, half);
      check_value("core_save_rdata even", 32'(half), 32'(save_word[i][31:16]));
      core_read({save_idx[i], 1'b1}, half);
      check_value("core_save_rdata odd", 32'(half), 32'(save_word[i][15:0]));
    end
    bridge_read({snes_bridge_pkg::window_cmd, 28'h0}, got);
    check_value("bridge_rd_data cmd window", got, 32'h0);
  endtask

  task automatic session_arbitration();
    logic [31:0] got;
    logic [15:0] new_upper;
    int n;
    new_upper = ~save_word[0][31:16];
    @(posedge clk_74a);
    dataslot_requestwrite <= 1'b1;
    @(posedge clk_74a);
    dataslot_requestwrite <= 1'b0;
    n = 0;
    @(negedge clk_74a);
    while (!save_download && n < 10) begin
      n++;
      @(negedge clk_74a);
    end
    assert (save_download) else stop_run("save_download did not rise after the request");
    // core write is locked out during the session
    core_write({save_idx[0], 1'b0}, new_upper);
    bridge_read(save_addr(save_idx[0]), got);
    check_value("bridge_rd_data in session", got, save_word[0]);
    @(posedge clk_74a);
    dataslot_allcomplete <= 1'b1;
    n = 0;
    @(negedge clk_74a);
    while (save_download && n < 10) begin
      n++;
      @(negedge clk_74a);
    end
    assert (!save_download) else stop_run("save_download did not fall after allcomplete");
    @(posedge clk_74a);
    dataslot_allcomplete <= 1'b0;
    core_write({save_idx[0], 1'b0}, new_upper);
    bridge_read(save_addr(save_idx[0]), got);
    check_value("bridge_rd_data after session", got, {new_upper, save_word[0][15:0]});
  endtask

  task automatic datatable_size();
    logic [3:0]  sizes    [3];
    logic [31:0] exp_data [3];
    sizes    = '{4'd0, 4'd1, 4'd5};
    exp_data = '{32'd0, 32'd2048, 32'd32768};
    for (int k = 0; k < 3; k++) begin
      bridge_write(snes_bridge_pkg::reg_ram_size, {28'h0, sizes[k]});
      @(posedge clk_74a);
      @(negedge clk_74a);
      check_value("datatable_data", datatable_data, exp_data[k]);
      check_value("datatable_wren", 32'(datatable_wren), 32'h1);
      check_value("datatable_addr", 32'(datatable_addr), 32'd3);
    end
  endtask

  task automatic rtc_toggle_and_fields();
    logic        prev;
    logic [31:0] date;
    logic [31:0] t;
    for (int k = 0; k < 3; k++) begin
      date = $urandom;
      t    = rtc_time ^ ($urandom | 32'h1);
      @(negedge clk_74a);
      prev = rtc.toggle;
      @(posedge clk_74a);
      rtc_date <= date;
      rtc_time <= t;
      @(posedge clk_74a);
      @(negedge clk_74a);
      check_value("rtc.toggle", 32'(rtc.toggle), 32'(!prev));
      check_value("rtc.weekday", 32'(rtc.weekday), 32'h1);
      check_value("rtc.pad", 32'(rtc.pad), 32'h0);
      check_value("rtc.year", 32'(rtc.year), 32'(date[23:16]));
      check_value("rtc.month", 32'(rtc.month), 32'(date[15:8]));
      check_value("rtc.day", 32'(rtc.day), 32'(date[7:0]));
      check_value("rtc.hour", 32'(rtc.hour), 32'(t[23:16]));
      check_value("rtc.minute", 32'(rtc.minute), 32'(t[15:8]));
      check_value("rtc.second", 32'(rtc.second), 32'(t[7:0]));
      // steady time, toggle holds
      repeat (4) begin
        @(negedge clk_74a);
        check_value("rtc.toggle steady", 32'(rtc.toggle), 32'(!prev));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(32'h273a));
    clk_74a               = 1'b0;
    pll_core_locked       = 1'b0;
    bridge                = '0;
    dataslot_requestread  = 1'b0;
    dataslot_requestwrite = 1'b0;
    dataslot_allcomplete  = 1'b0;
    rtc_date              = 32'h0;
    rtc_time              = 32'h0;
    core_save_req         = '0;
    repeat (8) @(posedge clk_74a);
    pll_core_locked <= 1'b1;

    settings_roundtrip();
    reset_pulse_length();
    save_window_access();
    session_arbitration();
    datatable_size();
    rtc_toggle_and_fields();

    repeat (2) @(posedge clk_74a);
    $display("Testbench passed");
    $finish;
  end

endmodule

/* sources.f */
logic/snes_bridge_pkg.sv
logic/bridge_settings_regs.sv
logic/save_slot_buffer.sv
logic/save_session_tracker.sv
logic/rtc_packer.sv
logic/bridge_read_mux.sv
logic/snes_bridge_top.sv
dv/snes_bridge_checker.sv
dv/snes_bridge_tb.sv

/* Makefile */
TOP := snes_bridge_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
